// ==== verilog.f ====
core_pkg.sv
sync_fifo.sv
dispatch_ctrl.sv
issue_queue.sv
alu_unit.sv
mul_unit.sv
cdb_arbiter.sv
backend_top.sv
backend_chk.sv
backend_tb.sv

// ==== Makefile ====
TOP := backend_tb
BIN := obj_dir/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

$(BIN): verilog.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -j 0 -f verilog.f --top-module $(TOP)

# exit status of the binary is the test verdict
sim: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== backend_tb.sv ====
module backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int NUM_FIXED       = 18;  // directed ops, tags 1..18
    localparam int NUM_RAND        = 16;  // random imm ops, tags 19..34
    localparam int NUM_OPS         = NUM_FIXED + NUM_RAND;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + 200;

    logic                      clk;
    logic                      rst_n_i;
    logic                      disp_valid_i;
    disp_uop_t                 disp_uop_i;
    logic                      disp_credit_o;
    cdb_info_t [CDB_COUNT-1:0] cdb_o;

    disp_uop_t           ops [NUM_OPS];        // stimulus in dispatch order
    logic [XLEN-1:0]     model_rf [PREG_NUM];  // expected value per tag
    logic [PREG_NUM-1:0] dispatched;
    int                  bcast_seen [PREG_NUM];
    int                  bcast_total;
    int                  credits;              // sender side credit count
    int                  n_ops;
    integer              seed;

    backend_top backend_top_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .disp_valid_i(disp_valid_i), .disp_uop_i(disp_uop_i),
        .disp_credit_o(disp_credit_o), .cdb_o(cdb_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                                name, exp, act));
        end
    endtask

    // ISA semantics, written from the op definitions
    function automatic logic [XLEN-1:0] expected_result(input op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] prod;
        int                sa;
        int                sb;
        prod = {32'b0, a} * {32'b0, b};
        sa   = a;  // reinterpret as signed
        sb   = b;
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return (sa < sb) ? 32'd1 : 32'd0;
            MUL:     return prod[XLEN-1:0];  // low word
            default: return '0;
        endcase
    endfunction

    // append one op and run it through the sequential model
    task automatic add_op(input op_e op, input int dest, input int src1, input int src2,
                          input logic use_imm, input logic [XLEN-1:0] imm);
        disp_uop_t       u;
        logic [XLEN-1:0] b;
        u.op           = op;
        u.dest         = PREG_W'(dest);
        u.src1         = PREG_W'(src1);
        u.src2         = PREG_W'(src2);
        u.use_imm      = use_imm;
        u.imm          = imm;
        b              = use_imm ? imm : model_rf[src2];
        model_rf[dest] = expected_result(op, model_rf[src1], b);
        ops[n_ops]     = u;
        n_ops++;
    endtask

    task automatic build_table();
        logic [31:0] r_op;
        logic [31:0] r_src;
        int          dest;
        for (int t = 0; t < PREG_NUM; t++) begin
            model_rf[t] = '0;  // every tag starts at 0
        end
        n_ops = 0;
        add_op(ADD, 1, 0, 0, 1'b1, 32'd5);           // independent imm ops
        add_op(ADD, 2, 0, 0, 1'b1, 32'h0000_1234);
        add_op(SUB, 3, 0, 0, 1'b1, 32'd7);           // negative result
        add_op(XOR, 4, 0, 0, 1'b1, 32'hdead_beef);
        add_op(ADD, 5, 1, 2, 1'b0, '0);              // dependent chain
        add_op(MUL, 6, 5, 3, 1'b0, '0);
        add_op(SLL, 7, 6, 0, 1'b1, 32'd3);
        add_op(SLT, 8, 3, 1, 1'b0, '0);              // signed, -7 < 5
        add_op(OR,  9, 7, 4, 1'b0, '0);
        add_op(SRL, 10, 9, 8, 1'b0, '0);             // shamt from a register
        add_op(AND, 11, 10, 0, 1'b1, 32'h0fff_f0ff);
        add_op(MUL, 12, 11, 6, 1'b0, '0);
        // mul burst, more than fifo plus pipeline outstanding
        for (int k = 0; k < 6; k++) begin
            add_op(MUL, 13 + k, 1 + k, 0, 1'b1, 32'h0001_0003 + k);
        end
        for (int k = 0; k < NUM_RAND; k++) begin
            dest  = NUM_FIXED + 1 + k;
            r_op  = $random(seed);
            r_src = $random(seed);
            add_op(op_e'(4'(r_op % 9)), dest, int'(r_src % dest), 0, 1'b1, $random(seed));
        end
    endtask

    task automatic record_result(input cdb_info_t res);
        if (!dispatched[res.tag]) begin
            abort_run($sformatf("tag %0d was broadcast but never dispatched", res.tag));
        end else if (bcast_seen[res.tag] != 0) begin
            abort_run($sformatf("tag %0d was broadcast more than once", res.tag));
        end else begin
            compare_value($sformatf("result tag %0d", res.tag), model_rf[res.tag], res.data);
            bcast_seen[res.tag]++;
            bcast_total++;
        end
    endtask

    // sample mid cycle, outputs settled
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (disp_credit_o) begin
                credits++;
                if (credits > DISP_DEPTH) begin
                    abort_run("more dispatch credits returned than were spent");
                end
            end
            for (int l = 0; l < CDB_COUNT; l++) begin
                if (cdb_o[l].valid) begin
                    record_result(cdb_o[l]);
                end
            end
        end else begin
            // lanes stay idle while in reset
            for (int l = 0; l < CDB_COUNT; l++) begin
                if (cdb_o[l].valid) begin
                    abort_run("a bus lane was valid during reset");
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles, %0d of %0d results broadcast",
                            WATCHDOG_CYCLES, bcast_total, NUM_OPS));
    end

    initial begin
        int i;
        seed         = 32'h2fb6_9032;
        rst_n_i      = 1'b0;
        disp_valid_i = 1'b0;
        disp_uop_i   = '0;
        credits      = DISP_DEPTH;
        bcast_total  = 0;
        dispatched   = '0;
        for (int t = 0; t < PREG_NUM; t++) begin
            bcast_seen[t] = 0;
        end
        build_table();
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        i = 0;
        while (i < NUM_OPS) begin
            @(posedge clk);
            if (credits > 0) begin
                disp_valid_i <= 1'b1;
                disp_uop_i   <= ops[i];
                dispatched[ops[i].dest] = 1'b1;
                credits--;  // spent on this push
                i++;
            end else begin
                disp_valid_i <= 1'b0;  // wait for a credit
            end
        end
        @(posedge clk);
        disp_valid_i <= 1'b0;
        wait (bcast_total == NUM_OPS);
        repeat (5) @(posedge clk);  // stray broadcasts would show here
        compare_value("returned credits", DISP_DEPTH, credits);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== backend_chk.sv ====
module backend_chk (
    input logic                                          clk,
    input logic                                          rst_n_i,
    input logic                                          disp_credit_i,
    input core_pkg::cdb_info_t [core_pkg::CDB_COUNT-1:0] cdb_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    // result fifos are empty in reset, so lanes stay idle
    reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> (!cdb_i[0].valid && !cdb_i[1].valid))
        else $error("bus lane valid while reset is asserted");

    // arbiter grants each source once per cycle, tags are unique in flight
    distinct_tags: assert property (@(posedge clk) disable iff (!rst_n_i)
        (cdb_i[0].valid && cdb_i[1].valid) |-> (cdb_i[0].tag != cdb_i[1].tag))
        else $error("both bus lanes carry the same tag");

    // dispatch buffer cannot have an entry yet
    no_early_credit: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !disp_credit_i)
        else $error("credit pulse in the first cycle after reset release");

endmodule

bind backend_top backend_chk backend_chk_i (
    .clk(clk), .rst_n_i(rst_n_i), .disp_credit_i(disp_credit_o), .cdb_i(cdb_o)
);

// ==== backend_top.sv ====
module backend_top (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          disp_valid_i,
    input  core_pkg::disp_uop_t                           disp_uop_i,
    output logic                                          disp_credit_o,
    output core_pkg::cdb_info_t [core_pkg::CDB_COUNT-1:0] cdb_o
);

    import core_pkg::*;

    logic                                buf_valid, buf_pop;
    disp_uop_t                           buf_head;
    logic [FU_COUNT-1:0]                 iq_not_full, iq_push;
    logic [FU_COUNT-1:0][IQ_CNT_W-1:0]   iq_count;    // alu entries feed steering
    iq_uop_t                             iq_uop;
    logic [FU_COUNT-1:0]                 fu_issue;
    exe_req_t [FU_COUNT-1:0]             fu_req;
    cdb_info_t [FU_COUNT-1:0]            fu_res;      // unit -> result fifo
    logic [FU_COUNT-1:0]                 res_valid, res_pop;
    cdb_info_t [FU_COUNT-1:0]            res_head;

    // input buffer, sized to the sender's credits
    sync_fifo #(.T(disp_uop_t), .DEPTH(DISP_DEPTH)) disp_fifo_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .push_i(disp_valid_i), .push_data_i(disp_uop_i), .pop_i(buf_pop),
        .valid_o(buf_valid), .head_o(buf_head), .count_o()
    );

    dispatch_ctrl dispatch_ctrl_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .buf_valid_i(buf_valid), .buf_uop_i(buf_head),
        .iq_not_full_i(iq_not_full), .iq_count_i(iq_count[1:0]), .cdb_i(cdb_o),
        .buf_pop_o(buf_pop), .disp_credit_o(disp_credit_o),
        .iq_push_o(iq_push), .iq_uop_o(iq_uop)
    );

    for (genvar i = 0; i < FU_COUNT; i++) begin : g_fu
        issue_queue iq_i (
            .clk(clk), .rst_n_i(rst_n_i),
            .push_i(iq_push[i]), .uop_i(iq_uop), .cdb_i(cdb_o), .res_pop_i(res_pop[i]),
            .not_full_o(iq_not_full[i]), .count_o(iq_count[i]),
            .issue_o(fu_issue[i]), .req_o(fu_req[i])
        );
        // push never stalls, queue credits cover the space
        sync_fifo #(.T(cdb_info_t), .DEPTH(RES_DEPTH)) res_fifo_i (
            .clk(clk), .rst_n_i(rst_n_i),
            .push_i(fu_res[i].valid), .push_data_i(fu_res[i]), .pop_i(res_pop[i]),
            .valid_o(res_valid[i]), .head_o(res_head[i]), .count_o()
        );
    end

    for (genvar i = 0; i < FU_COUNT - 1; i++) begin : g_alu
        alu_unit alu_i (
            .clk(clk), .rst_n_i(rst_n_i),
            .issue_i(fu_issue[i]), .req_i(fu_req[i]), .res_o(fu_res[i])
        );
    end

    mul_unit mul_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .issue_i(fu_issue[FU_COUNT-1]), .req_i(fu_req[FU_COUNT-1]),
        .res_o(fu_res[FU_COUNT-1])
    );

    cdb_arbiter cdb_arbiter_i (
        .clk(clk), .rst_n_i(rst_n_i),
        .head_valid_i(res_valid), .head_i(res_head),
        .pop_o(res_pop), .cdb_o(cdb_o)
    );

endmodule

// ==== cdb_arbiter.sv ====
module cdb_arbiter (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic [core_pkg::FU_COUNT-1:0]                 head_valid_i,
    input  core_pkg::cdb_info_t [core_pkg::FU_COUNT-1:0]  head_i,
    output logic [core_pkg::FU_COUNT-1:0]                 pop_o,
    output core_pkg::cdb_info_t [core_pkg::CDB_COUNT-1:0] cdb_o
);

    import core_pkg::*;

    logic [FU_IDX_W-1:0] ptr_q;  // search start, rotates
    logic                any_grant;
    int                  last;   // last granted source

    always_comb begin
        int idx;
        int n;
        pop_o     = '0;
        cdb_o     = '0;
        n         = 0;
        last      = int'(ptr_q);
        any_grant = 1'b0;
        for (int k = 0; k < FU_COUNT; k++) begin
            idx = (int'(ptr_q) + k) % FU_COUNT;
            if (head_valid_i[idx] && n < CDB_COUNT) begin
                pop_o[idx]     = 1'b1;
                cdb_o[n]       = head_i[idx];
                cdb_o[n].valid = 1'b1;
                last           = idx;
                any_grant      = 1'b1;
                n              = n + 1;  // first free lane
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (any_grant) begin
            ptr_q <= FU_IDX_W'((last + 1) % FU_COUNT);  // skip past winner
        end
    end

endmodule

// ==== mul_unit.sv ====
module mul_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                issue_i,
    input  core_pkg::exe_req_t  req_i,
    output core_pkg::cdb_info_t res_o
);

    import core_pkg::*;

    logic [31:0]           pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;  // stage 1
    logic [63:0]           sum_q;                               // stage 2
    logic [XLEN-1:0]       prod_q;                              // stage 3, low word
    logic [MUL_STAGES-1:0] vld_q;                               // valid travels alongside
    logic [PREG_W-1:0]     tag_q [MUL_STAGES];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], issue_i};
        end
    end

    always_ff @(posedge clk) begin
        pp_ll_q <= req_i.src1_val[15:0]  * req_i.src2_val[15:0];
        pp_lh_q <= req_i.src1_val[15:0]  * req_i.src2_val[31:16];
        pp_hl_q <= req_i.src1_val[31:16] * req_i.src2_val[15:0];
        pp_hh_q <= req_i.src1_val[31:16] * req_i.src2_val[31:16];
        sum_q   <= {pp_hh_q, 32'b0} + ({32'b0, pp_lh_q} << 16)
                 + ({32'b0, pp_hl_q} << 16) + {32'b0, pp_ll_q};
        prod_q  <= sum_q[XLEN-1:0];  // high word dropped
        tag_q[0] <= req_i.dest;
        for (int s = 1; s < MUL_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
    end

    assign res_o = cdb_info_t'{valid: vld_q[MUL_STAGES-1], tag: tag_q[MUL_STAGES-1],
                               data: prod_q};

endmodule

// ==== alu_unit.sv ====
module alu_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                issue_i,
    input  core_pkg::exe_req_t  req_i,
    output core_pkg::cdb_info_t res_o  // valid doubles as fifo push
);

    import core_pkg::*;

    logic [XLEN-1:0]   a, b, result;
    logic              valid_q;
    logic [PREG_W-1:0] tag_q;
    logic [XLEN-1:0]   data_q;

    assign a = req_i.src1_val;
    assign b = req_i.src2_val;

    always_comb begin
        case (req_i.op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << b[4:0];
            SRL:     result = a >> b[4:0];  // logical
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = '0;           // mul never steered here
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            tag_q  <= req_i.dest;
            data_q <= result;
        end
    end

    assign res_o = cdb_info_t'{valid: valid_q, tag: tag_q, data: data_q};

endmodule

// ==== issue_queue.sv ====
module issue_queue (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          push_i,
    input  core_pkg::iq_uop_t                             uop_i,
    input  core_pkg::cdb_info_t [core_pkg::CDB_COUNT-1:0] cdb_i,
    input  logic                                          res_pop_i,  // result fifo pop
    output logic                                          not_full_o,
    output logic [core_pkg::IQ_CNT_W-1:0]                 count_o,
    output logic                                          issue_o,
    output core_pkg::exe_req_t                            req_o
);

    import core_pkg::*;

    // collapsing queue, slot 0 is always the oldest
    iq_uop_t              ent_q [IQ_DEPTH];
    iq_uop_t              woke  [IQ_DEPTH];
    iq_uop_t              nxt   [IQ_DEPTH];
    logic [IQ_CNT_W-1:0]  count_q;
    logic [RES_CNT_W-1:0] credit_q;  // free result fifo slots
    logic [IQ_IDX_W-1:0]  sel;
    logic                 found;
    logic [IQ_CNT_W-1:0]  fill;      // push slot after collapse

    function automatic operand_t wake(input operand_t opd,
                                      input cdb_info_t [CDB_COUNT-1:0] bus);
        operand_t res;
        res = opd;
        for (int l = 0; l < CDB_COUNT; l++) begin
            if (bus[l].valid && !opd.ready && bus[l].tag == opd.tag) begin
                res.ready = 1'b1;
                res.value = bus[l].data;
            end
        end
        return res;
    endfunction

    // oldest entry with both operands ready, from registered state
    always_comb begin
        sel   = '0;
        found = 1'b0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (i < count_q && ent_q[i].src1.ready && ent_q[i].src2.ready) begin
                sel   = IQ_IDX_W'(i);
                found = 1'b1;
            end
        end
    end

    assign issue_o          = found && (credit_q != '0);
    assign req_o.op         = ent_q[sel].op;
    assign req_o.dest       = ent_q[sel].dest;
    assign req_o.src1_val   = ent_q[sel].src1.value;
    assign req_o.src2_val   = ent_q[sel].src2.value;
    assign not_full_o       = (count_q < IQ_DEPTH);
    assign count_o          = count_q;
    assign fill             = count_q - IQ_CNT_W'(issue_o);

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            woke[i].op   = ent_q[i].op;
            woke[i].dest = ent_q[i].dest;
            woke[i].src1 = wake(ent_q[i].src1, cdb_i);
            woke[i].src2 = wake(ent_q[i].src2, cdb_i);
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            nxt[i] = woke[i];
        end
        if (issue_o) begin
            for (int i = 0; i < IQ_DEPTH - 1; i++) begin
                if (i >= sel) begin
                    nxt[i] = woke[i+1];  // close the gap
                end
            end
        end
        if (push_i) begin
            nxt[fill[IQ_IDX_W-1:0]] = uop_i;  // already bypassed at steer
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q  <= '0;
            credit_q <= RES_CNT_W'(RES_DEPTH);
        end else begin
            count_q  <= fill + IQ_CNT_W'(push_i);
            credit_q <= credit_q - RES_CNT_W'(issue_o) + RES_CNT_W'(res_pop_i);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ent_q[i] <= nxt[i];
        end
    end

endmodule

// ==== dispatch_ctrl.sv ====
module dispatch_ctrl (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic                                              buf_valid_i,
    input  core_pkg::disp_uop_t                               buf_uop_i,
    input  logic [core_pkg::FU_COUNT-1:0]                     iq_not_full_i,
    input  logic [1:0][core_pkg::IQ_CNT_W-1:0]                iq_count_i,  // alu queues only
    input  core_pkg::cdb_info_t [core_pkg::CDB_COUNT-1:0]     cdb_i,
    output logic                                              buf_pop_o,
    output logic                                              disp_credit_o,
    output logic [core_pkg::FU_COUNT-1:0]                     iq_push_o,
    output core_pkg::iq_uop_t                                 iq_uop_o
);

    import core_pkg::*;

    logic [XLEN-1:0]     prf_q [PREG_NUM];  // physical register file
    logic [PREG_NUM-1:0] ready_q;           // scoreboard
    logic                is_mul;
    logic [FU_COUNT-1:0] target;            // one-hot queue select
    logic                steer;

    // bus bypass first, then regfile if the tag is already written
    function automatic operand_t lookup(input logic [PREG_W-1:0] tag);
        operand_t opd;
        opd.ready = ready_q[tag];
        opd.tag   = tag;
        opd.value = prf_q[tag];
        for (int l = 0; l < CDB_COUNT; l++) begin
            if (cdb_i[l].valid && cdb_i[l].tag == tag) begin
                opd.ready = 1'b1;
                opd.value = cdb_i[l].data;
            end
        end
        return opd;
    endfunction

    always_comb begin
        is_mul = (buf_uop_i.op == MUL);
        if (is_mul) begin
            target = 3'b100;
        end else if (iq_count_i[1] < iq_count_i[0]) begin
            target = 3'b010;  // queue 1 strictly emptier
        end else begin
            target = 3'b001;  // ties go to queue 0
        end
        // chosen alu queue full means both are full
        steer = buf_valid_i && ((target & iq_not_full_i) != '0);
    end

    always_comb begin
        iq_uop_o.op   = buf_uop_i.op;
        iq_uop_o.dest = buf_uop_i.dest;
        iq_uop_o.src1 = lookup(buf_uop_i.src1);
        iq_uop_o.src2 = lookup(buf_uop_i.src2);
        if (buf_uop_i.use_imm) begin
            iq_uop_o.src2.ready = 1'b1;
            iq_uop_o.src2.value = buf_uop_i.imm;
        end
    end

    assign iq_push_o     = steer ? target : '0;
    assign buf_pop_o     = steer;
    assign disp_credit_o = steer;  // one credit back per pop

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= '1;  // every tag holds 0 and is ready
            for (int t = 0; t < PREG_NUM; t++) begin
                prf_q[t] <= '0;
            end
        end else begin
            for (int l = 0; l < CDB_COUNT; l++) begin
                if (cdb_i[l].valid) begin
                    prf_q[cdb_i[l].tag]   <= cdb_i[l].data;
                    ready_q[cdb_i[l].tag] <= 1'b1;
                end
            end
            if (steer) begin
                ready_q[buf_uop_i.dest] <= 1'b0;  // new producer in flight
            end
        end
    end

endmodule

// ==== sync_fifo.sv ====
module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       push_i,
    input  T                           push_data_i,
    input  logic                       pop_i,
    output logic                       valid_o,
    output T                           head_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    T                           mem_q [DEPTH];  // storage, no reset
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] cnt_q;
    logic                       do_pop;

    assign do_pop  = pop_i && valid_o;  // pop on empty is ignored
    assign valid_o = (cnt_q != '0);
    assign head_o  = mem_q[rd_ptr_q];
    assign count_o = cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            cnt_q <= cnt_q + push_i - do_pop;  // sender guarantees no overflow
        end
    end

    // write port, entry readable from the next cycle on
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

// ==== core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;  // datapath width
    localparam int PREG_W     = 6;   // physical tag width
    localparam int PREG_NUM   = 64;
    localparam int CDB_COUNT  = 2;   // bus lanes
    localparam int FU_COUNT   = 3;   // 0,1 alu / 2 mul
    localparam int DISP_DEPTH = 4;   // also the sender's initial credits
    localparam int IQ_DEPTH   = 4;
    localparam int RES_DEPTH  = 2;   // per unit result fifo
    localparam int MUL_STAGES = 3;

    // derived widths
    localparam int IQ_IDX_W  = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W  = $clog2(IQ_DEPTH + 1);
    localparam int RES_CNT_W = $clog2(RES_DEPTH + 1);
    localparam int FU_IDX_W  = $clog2(FU_COUNT);

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,  // shamt = src2[4:0]
        SRL,
        SLT,  // signed compare
        MUL   // low word only
    } op_e;

    // micro-op as seen on the dispatch port
    typedef struct packed {
        op_e               op;
        logic [PREG_W-1:0] dest;
        logic [PREG_W-1:0] src1;
        logic [PREG_W-1:0] src2;
        logic              use_imm;  // src2 replaced by imm
        logic [XLEN-1:0]   imm;
    } disp_uop_t;

    typedef struct packed {
        logic              ready;
        logic [PREG_W-1:0] tag;
        logic [XLEN-1:0]   value;
    } operand_t;

    // steered op, one per issue queue slot
    typedef struct packed {
        op_e               op;
        logic [PREG_W-1:0] dest;
        operand_t          src1;
        operand_t          src2;
    } iq_uop_t;

    typedef struct packed {
        op_e               op;
        logic [PREG_W-1:0] dest;
        logic [XLEN-1:0]   src1_val;
        logic [XLEN-1:0]   src2_val;
    } exe_req_t;

    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] tag;
        logic [XLEN-1:0]   data;
    } cdb_info_t;

endpackage
